// ==== hdl/lineFilterPkg.sv ====
`default_nettype none

package lineFilterPkg;

    // controller phases
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        TRANSFER = 2'd1,
        PROCESS  = 2'd2,
        DONE     = 2'd3
    } filterState_t;

    // address width covers the longest line
    localparam int DEF_ADDRESS_W = 10;

    localparam int DEF_PIXEL_W = 8;

    // cycles from sample strobe to result strobe
    localparam int DEF_LATENCY = 4;

endpackage

`default_nettype wire

// ==== hdl/lineAddrCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module lineAddrCounter #(
    parameter int ADDRESS_W = lineFilterPkg::DEF_ADDRESS_W
) (
    input  wire                  i_CLK,
    input  wire                  i_reset,
    input  wire  [ADDRESS_W-1:0] i_imgLength,
    input  wire                  i_latchLength,
    input  wire                  i_clear,
    input  wire                  i_readbackMode,
    input  wire                  i_transferStep,
    input  wire                  i_readStep,
    input  wire                  i_writeStep,
    output logic [ADDRESS_W-1:0] o_transferAdd,
    output logic [ADDRESS_W-1:0] o_readAdd,
    output logic [ADDRESS_W-1:0] o_writeAdd,
    output logic                 o_lastTransfer,
    output logic                 o_lastRead,
    output logic                 o_lastWrite
);
    logic [ADDRESS_W-1:0] lineLength;
    logic [ADDRESS_W-1:0] lengthMinus2;
    logic [ADDRESS_W-1:0] transferLimit;

    // last result address, imgLength-1 results per line
    assign lengthMinus2 = lineLength - ADDRESS_W'(2);

    // readback stops at the last result, load at the last pixel
    assign transferLimit = i_readbackMode ? lengthMinus2 : lineLength;

    assign o_lastTransfer = (o_transferAdd == transferLimit);
    assign o_lastRead     = (o_readAdd == lineLength);
    assign o_lastWrite    = (o_writeAdd == lengthMinus2);

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            lineLength <= '0;
        end else if (i_latchLength) begin
            lineLength <= i_imgLength;
        end
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset || i_clear) begin
            o_transferAdd <= '0;
            o_readAdd     <= '0;
            o_writeAdd    <= '0;
        end else begin
            if (i_transferStep) begin
                o_transferAdd <= o_transferAdd + 1'b1;
            end
            if (i_readStep) begin
                o_readAdd <= o_readAdd + 1'b1;
            end
            if (i_writeStep) begin
                o_writeAdd <= o_writeAdd + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pixelBuffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixelBuffer #(
    parameter int ADDRESS_W = lineFilterPkg::DEF_ADDRESS_W,
    parameter int DATA_W    = lineFilterPkg::DEF_PIXEL_W
) (
    input  wire                  i_CLK,
    input  wire                  i_writeEn,
    input  wire  [ADDRESS_W-1:0] i_writeAdd,
    input  wire  [DATA_W-1:0]    i_writeData,
    input  wire                  i_readEn,
    input  wire  [ADDRESS_W-1:0] i_readAdd,
    output logic [DATA_W-1:0]    o_readData
);
    logic [DATA_W-1:0] mem [2**ADDRESS_W];

    // read data holds while no read is issued
    always_ff @(posedge i_CLK) begin
        if (i_writeEn) begin
            mem[i_writeAdd] <= i_writeData;
        end
        if (i_readEn) begin
            o_readData <= mem[i_readAdd];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/smoothConv3.sv ====
`timescale 1ns/100ps
`default_nettype none

module smoothConv3 #(
    parameter int PIXEL_W = lineFilterPkg::DEF_PIXEL_W,
    parameter int LATENCY = lineFilterPkg::DEF_LATENCY
) (
    input  wire                i_CLK,
    input  wire                i_reset,
    input  wire                i_clear,
    input  wire                i_sampleStrobe,
    input  wire  [PIXEL_W-1:0] i_sample,
    output logic [PIXEL_W+1:0] o_result,
    output logic               o_resultStrobe
);
    localparam int RESULT_W = PIXEL_W + 2;
    localparam int DELAY    = LATENCY - 2;

    logic                sampleAligned;
    logic [1:0]          fillCount;
    logic [PIXEL_W-1:0]  tapMid;
    logic [PIXEL_W-1:0]  tapOld;
    logic [RESULT_W-1:0] weightedSum;
    logic [RESULT_W-1:0] sumReg;
    logic                sumValid;

    // incoming sample is the newest tap, kernel 1-2-1
    assign weightedSum = RESULT_W'(i_sample) + (RESULT_W'(tapMid) << 1) + RESULT_W'(tapOld);

    // strobe lags one cycle to meet the buffer read data
    always_ff @(posedge i_CLK) begin
        if (i_reset || i_clear) begin
            sampleAligned <= 1'b0;
            fillCount     <= 2'd0;
            sumValid      <= 1'b0;
        end else begin
            sampleAligned <= i_sampleStrobe;
            sumValid      <= sampleAligned && (fillCount == 2'd2);
            if (sampleAligned && (fillCount != 2'd2)) begin
                fillCount <= fillCount + 1'b1;
            end
        end
    end

    always_ff @(posedge i_CLK) begin
        if (sampleAligned) begin
            tapOld <= tapMid;
            tapMid <= i_sample;
            sumReg <= weightedSum;
        end
    end

    // pad out to the requested latency
    generate
        if (DELAY == 0) begin : gNoDelay
            assign o_result       = sumReg;
            assign o_resultStrobe = sumValid;
        end else begin : gDelay
            logic [RESULT_W-1:0] resultPipe [DELAY];
            logic [DELAY-1:0]    strobePipe;

            always_ff @(posedge i_CLK) begin
                if (i_reset || i_clear) begin
                    strobePipe <= '0;
                end else begin
                    strobePipe[0] <= sumValid;
                    for (int i = 1; i < DELAY; i++) begin
                        strobePipe[i] <= strobePipe[i-1];
                    end
                end
            end

            always_ff @(posedge i_CLK) begin
                resultPipe[0] <= sumReg;
                for (int i = 1; i < DELAY; i++) begin
                    resultPipe[i] <= resultPipe[i-1];
                end
            end

            assign o_result       = resultPipe[DELAY-1];
            assign o_resultStrobe = strobePipe[DELAY-1];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/lineFilterFsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module lineFilterFsm (
    input  wire  i_CLK,
    input  wire  i_reset,
    input  wire  i_load,
    input  wire  i_SoP,
    input  wire  i_valid,
    input  wire  i_lastTransfer,
    input  wire  i_lastRead,
    input  wire  i_lastWrite,
    input  wire  i_resultStrobe,
    output logic o_latchLength,
    output logic o_clearCounters,
    output logic o_readbackMode,
    output logic o_transferStep,
    output logic o_readStep,
    output logic o_loadWrite,
    output logic o_readbackRead,
    output logic o_sampleStrobe,
    output logic o_changeBlock,
    output logic o_EoP,
    output logic o_processing
);
    import lineFilterPkg::*;

    filterState_t state;
    logic validPrev;
    logic validEdge;
    logic readbackMode;
    logic endOfProcess;
    logic readDone;
    logic changeBlock;
    logic startLoad;
    logic startProcess;
    logic startReadback;
    logic transferEvent;
    logic lastEdge;

    assign validEdge = i_valid & ~validPrev;

    // legal phase starts out of IDLE
    assign startLoad     = (state == IDLE) && i_load && !i_SoP && !endOfProcess;
    assign startProcess  = (state == IDLE) && !i_load && i_SoP && !endOfProcess;
    assign startReadback = (state == IDLE) && !i_load && !i_SoP && endOfProcess;

    assign transferEvent = (state == TRANSFER) && validEdge;
    assign lastEdge      = transferEvent && i_lastTransfer;

    assign o_latchLength   = startLoad;
    assign o_clearCounters = startLoad | startProcess | startReadback;
    assign o_readbackMode  = readbackMode;
    assign o_transferStep  = transferEvent;
    assign o_loadWrite     = transferEvent && !readbackMode;
    assign o_readbackRead  = transferEvent && readbackMode;

    // one address per cycle until the last pixel has been read
    assign o_sampleStrobe = (state == PROCESS) && !readDone;
    assign o_readStep     = o_sampleStrobe;

    assign o_changeBlock = changeBlock;
    assign o_EoP         = endOfProcess;
    assign o_processing  = (state == PROCESS);

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            state        <= IDLE;
            validPrev    <= 1'b0;
            readbackMode <= 1'b0;
            endOfProcess <= 1'b0;
            readDone     <= 1'b0;
            changeBlock  <= 1'b0;
        end else begin
            validPrev   <= i_valid;
            changeBlock <= lastEdge;
            case (state)
                IDLE: begin
                    readDone <= 1'b0;
                    if (startLoad) begin
                        state        <= TRANSFER;
                        readbackMode <= 1'b0;
                    end else if (startProcess) begin
                        state <= PROCESS;
                    end else if (startReadback) begin
                        state        <= TRANSFER;
                        readbackMode <= 1'b1;
                    end
                end
                TRANSFER: begin
                    if (lastEdge) begin
                        state <= IDLE;
                        // results consumed, ready for the next line
                        if (readbackMode) begin
                            endOfProcess <= 1'b0;
                        end
                    end
                end
                PROCESS: begin
                    if (o_sampleStrobe && i_lastRead) begin
                        readDone <= 1'b1;
                    end
                    if (i_resultStrobe && i_lastWrite) begin
                        endOfProcess <= 1'b1;
                        state        <= DONE;
                    end
                end
                DONE: begin
                    if (!i_SoP) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lineFilterTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module lineFilterTop #(
    parameter int ADDRESS_W = lineFilterPkg::DEF_ADDRESS_W,
    parameter int PIXEL_W   = lineFilterPkg::DEF_PIXEL_W,
    parameter int LATENCY   = lineFilterPkg::DEF_LATENCY
) (
    input  wire                  i_CLK,
    input  wire                  i_reset,
    input  wire  [ADDRESS_W-1:0] i_imgLength,
    input  wire                  i_load,
    input  wire                  i_SoP,
    input  wire                  i_valid,
    input  wire  [PIXEL_W-1:0]   i_pixel,
    output logic [PIXEL_W+1:0]   o_result,
    output logic                 o_resultValid,
    output logic                 o_changeBlock,
    output logic                 o_EoP,
    output logic                 o_processing
);
    localparam int RESULT_W = PIXEL_W + 2;

    logic                 latchLength;
    logic                 clearCounters;
    logic                 readbackMode;
    logic                 transferStep;
    logic                 readStep;
    logic                 loadWrite;
    logic                 readbackRead;
    logic                 sampleStrobe;
    logic                 lastTransfer;
    logic                 lastRead;
    logic                 lastWrite;
    logic [ADDRESS_W-1:0] transferAdd;
    logic [ADDRESS_W-1:0] readAdd;
    logic [ADDRESS_W-1:0] writeAdd;
    logic [PIXEL_W-1:0]   pixelData;
    logic [RESULT_W-1:0]  convResult;
    logic                 resultStrobe;

    lineFilterFsm uFsm (
        .i_CLK           (i_CLK),
        .i_reset         (i_reset),
        .i_load          (i_load),
        .i_SoP           (i_SoP),
        .i_valid         (i_valid),
        .i_lastTransfer  (lastTransfer),
        .i_lastRead      (lastRead),
        .i_lastWrite     (lastWrite),
        .i_resultStrobe  (resultStrobe),
        .o_latchLength   (latchLength),
        .o_clearCounters (clearCounters),
        .o_readbackMode  (readbackMode),
        .o_transferStep  (transferStep),
        .o_readStep      (readStep),
        .o_loadWrite     (loadWrite),
        .o_readbackRead  (readbackRead),
        .o_sampleStrobe  (sampleStrobe),
        .o_changeBlock   (o_changeBlock),
        .o_EoP           (o_EoP),
        .o_processing    (o_processing)
    );

    lineAddrCounter #(.ADDRESS_W(ADDRESS_W)) uCounter (
        .i_CLK          (i_CLK),
        .i_reset        (i_reset),
        .i_imgLength    (i_imgLength),
        .i_latchLength  (latchLength),
        .i_clear        (clearCounters),
        .i_readbackMode (readbackMode),
        .i_transferStep (transferStep),
        .i_readStep     (readStep),
        .i_writeStep    (resultStrobe),
        .o_transferAdd  (transferAdd),
        .o_readAdd      (readAdd),
        .o_writeAdd     (writeAdd),
        .o_lastTransfer (lastTransfer),
        .o_lastRead     (lastRead),
        .o_lastWrite    (lastWrite)
    );

    // input line, loaded by the host and read by the convolver
    pixelBuffer #(.ADDRESS_W(ADDRESS_W), .DATA_W(PIXEL_W)) uInputBuffer (
        .i_CLK       (i_CLK),
        .i_writeEn   (loadWrite),
        .i_writeAdd  (transferAdd),
        .i_writeData (i_pixel),
        .i_readEn    (sampleStrobe),
        .i_readAdd   (readAdd),
        .o_readData  (pixelData)
    );

    smoothConv3 #(.PIXEL_W(PIXEL_W), .LATENCY(LATENCY)) uConv (
        .i_CLK          (i_CLK),
        .i_reset        (i_reset),
        .i_clear        (clearCounters),
        .i_sampleStrobe (sampleStrobe),
        .i_sample       (pixelData),
        .o_result       (convResult),
        .o_resultStrobe (resultStrobe)
    );

    // results, written behind the read address and read back by the host
    pixelBuffer #(.ADDRESS_W(ADDRESS_W), .DATA_W(RESULT_W)) uResultBuffer (
        .i_CLK       (i_CLK),
        .i_writeEn   (resultStrobe),
        .i_writeAdd  (writeAdd),
        .i_writeData (convResult),
        .i_readEn    (readbackRead),
        .i_readAdd   (transferAdd),
        .o_readData  (o_result)
    );

    // matches the one-cycle buffer read
    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            o_resultValid <= 1'b0;
        end else begin
            o_resultValid <= readbackRead;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/lineFilterFsm_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module lineFilterFsm_sva (
    input wire                         i_CLK,
    input wire                         i_reset,
    input var lineFilterPkg::filterState_t i_state,
    input wire                         i_sampleStrobe,
    input wire                         i_changeBlock,
    input wire                         i_EoP,
    input wire                         i_processing,
    input wire                         i_lastEdge,
    input wire                         i_readbackMode
);
    import lineFilterPkg::*;

    // one unbroken run of addresses per PROCESS phase
    sampleRunContiguous: assert property (@(posedge i_CLK) disable iff (i_reset)
        ((i_state == PROCESS) && !i_sampleStrobe) |=> !i_sampleStrobe)
    else $error("sample strobe restarted within PROCESS");

    changeBlockPulse: assert property (@(posedge i_CLK) disable iff (i_reset)
        i_changeBlock |=> !i_changeBlock)
    else $error("changeBlock longer than one cycle");

    // only the last readback edge may clear end of process
    eopHeld: assert property (@(posedge i_CLK) disable iff (i_reset)
        (i_EoP && !(i_lastEdge && i_readbackMode)) |=> i_EoP)
    else $error("EoP fell outside a readback end");

    // no new line is processed while results are pending
    processingWithoutEoP: assert property (@(posedge i_CLK) disable iff (i_reset)
        i_processing |-> !i_EoP)
    else $error("processing while results are pending");

endmodule

bind lineFilterFsm lineFilterFsm_sva uFsmSva (
    .i_CLK          (i_CLK),
    .i_reset        (i_reset),
    .i_state        (state),
    .i_sampleStrobe (o_sampleStrobe),
    .i_changeBlock  (o_changeBlock),
    .i_EoP          (o_EoP),
    .i_processing   (o_processing),
    .i_lastEdge     (lastEdge),
    .i_readbackMode (readbackMode)
);

`default_nettype wire

// ==== testbench/lineFilterTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lineFilterTb;
    import lineFilterPkg::*;

    localparam int ADDRESS_W  = DEF_ADDRESS_W;
    localparam int PIXEL_W    = DEF_PIXEL_W;
    localparam int RESULT_W   = DEF_PIXEL_W + 2;
    localparam int LATENCY    = DEF_LATENCY;
    localparam int NUM_LINES  = 8;
    localparam int MAX_LENGTH = 60;
    localparam logic [31:0] SEED = 32'h6f23_e7b0;
    // load and readback at up to 8 cycles per pixel, plus processing
    localparam int LINE_CYCLES    = (MAX_LENGTH + 1) * 8 * 2 + MAX_LENGTH + 1 + LATENCY + 16;
    localparam int TIMEOUT_CYCLES = NUM_LINES * LINE_CYCLES + 200;
    // short decoy length, enough edges in the ignored load to end a block
    localparam int DECOY_LENGTH = 3;
    localparam int DECOY_PULSES = DECOY_LENGTH + 3;

    logic                 clk = 1'b0;
    logic                 reset;
    logic [ADDRESS_W-1:0] imgLength;
    logic                 load;
    logic                 startOfProcess;
    logic                 valid;
    logic [PIXEL_W-1:0]   pixel;
    logic [RESULT_W-1:0]  result;
    logic                 resultValid;
    logic                 changeBlock;
    logic                 endOfProcess;
    logic                 processing;

    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int lineIndex  = 0;
    logic [PIXEL_W-1:0] linePixels[$];
    int expResults[$];

    lineFilterTop uut (
        .i_CLK         (clk),
        .i_reset       (reset),
        .i_imgLength   (imgLength),
        .i_load        (load),
        .i_SoP         (startOfProcess),
        .i_valid       (valid),
        .i_pixel       (pixel),
        .o_result      (result),
        .o_resultValid (resultValid),
        .o_changeBlock (changeBlock),
        .o_EoP         (endOfProcess),
        .o_processing  (processing)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount == TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checkCount, errorCount);
            $display("Regression failed");
            $finish;
        end
    end

    // outputs settle at the edge, inputs change 1 ns later
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkEqual(input string testName, input int expected, input int actual);
        checkCount++;
        if (expected != actual) begin
            errorCount++;
            $display("** Error line %0d %s: expected %0d, actual %0d at %0t",
                     lineIndex, testName, expected, actual, $time);
        end
    endtask

    // 1-2-1 kernel over three neighbouring pixels
    function automatic int smoothRef(input int left, input int mid, input int right);
        return left + 2 * mid + right;
    endfunction

    task automatic loadLine(input int len);
        logic [PIXEL_W-1:0] value;
        linePixels.delete();
        expResults.delete();
        imgLength = ADDRESS_W'(len);
        load = 1'b1;
        nextCycle();
        load = 1'b0;
        for (int i = 0; i <= len; i++) begin
            value = PIXEL_W'($urandom);
            linePixels.push_back(value);
            pixel = value;
            valid = 1'b1;
            nextCycle();
            valid = 1'b0;
            checkEqual("load changeBlock", (i == len) ? 1 : 0, int'(changeBlock));
            repeat ($urandom_range(3, 1)) begin
                nextCycle();
                checkEqual("load gap changeBlock", 0, int'(changeBlock));
            end
        end
        for (int k = 0; k < len - 1; k++) begin
            expResults.push_back(smoothRef(int'(linePixels[k]), int'(linePixels[k+1]),
                                           int'(linePixels[k+2])));
        end
    endtask

    task automatic processLine(input int len);
        int cycles;
        startOfProcess = 1'b1;
        nextCycle();
        checkEqual("processing start", 1, int'(processing));
        cycles = 0;
        while (!endOfProcess && cycles < LINE_CYCLES) begin
            nextCycle();
            cycles++;
        end
        checkEqual("EoP latency", len + 1 + LATENCY, cycles);
        checkEqual("processing after EoP", 0, int'(processing));
        // a full load attempt while results are pending must not start a block
        startOfProcess = 1'b0;
        load = 1'b1;
        imgLength = ADDRESS_W'(DECOY_LENGTH);
        for (int i = 0; i < DECOY_PULSES; i++) begin
            pixel = PIXEL_W'($urandom);
            valid = 1'b1;
            nextCycle();
            valid = 1'b0;
            checkEqual("ignored load changeBlock", 0, int'(changeBlock));
            checkEqual("EoP held", 1, int'(endOfProcess));
            nextCycle();
            checkEqual("ignored load changeBlock", 0, int'(changeBlock));
            checkEqual("EoP held", 1, int'(endOfProcess));
        end
        load = 1'b0;
        nextCycle();
    endtask

    task automatic readbackLine(input int len);
        for (int k = 0; k < len - 1; k++) begin
            valid = 1'b1;
            nextCycle();
            valid = 1'b0;
            checkEqual("readback valid", 1, int'(resultValid));
            checkEqual("readback result", expResults[k], int'(result));
            checkEqual("readback changeBlock", (k == len - 2) ? 1 : 0, int'(changeBlock));
            checkEqual("readback EoP", (k == len - 2) ? 0 : 1, int'(endOfProcess));
            repeat ($urandom_range(3, 1)) begin
                nextCycle();
                checkEqual("readback gap valid", 0, int'(resultValid));
                checkEqual("readback gap changeBlock", 0, int'(changeBlock));
            end
        end
    endtask

    initial begin
        int len;
        void'($urandom(SEED));
        reset          = 1'b1;
        imgLength      = '0;
        load           = 1'b0;
        startOfProcess = 1'b0;
        valid          = 1'b0;
        pixel          = '0;
        repeat (3) nextCycle();
        checkEqual("reset resultValid", 0, int'(resultValid));
        checkEqual("reset changeBlock", 0, int'(changeBlock));
        checkEqual("reset EoP", 0, int'(endOfProcess));
        checkEqual("reset processing", 0, int'(processing));
        reset = 1'b0;
        nextCycle();
        for (int line = 0; line < NUM_LINES; line++) begin
            lineIndex = line;
            len = $urandom_range(MAX_LENGTH, 3);
            loadLine(len);
            processLine(len);
            readbackLine(len);
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/lineFilterPkg.sv
hdl/lineAddrCounter.sv
hdl/pixelBuffer.sv
hdl/smoothConv3.sv
hdl/lineFilterFsm.sv
hdl/lineFilterTop.sv
testbench/lineFilterFsm_sva.sv
testbench/lineFilterTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = lineFilterTb
FILE_LIST  = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Regression failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# a crash or assertion stop counts as a failure in the log
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
